//--- verif/wb_patterns.txt
// Per line, pipe 0 then pipe 1, each: offset seq waddr wdata wen (hex)
// offset = idle cycles before the result is offered, seq = 2*line (+1) mod 16
0 0 01 a0000000 1  2 1 02 b0000001 1
1 2 03 a0000002 1  0 3 00 b0000003 1
0 4 04 a0000004 0  3 5 05 b0000005 1
2 6 06 a0000006 1  0 7 07 b0000007 1
0 8 00 a0000008 1  1 9 09 b0000009 0
3 a 0a a000000a 1  0 b 0b b000000b 1
0 c 0c a000000c 1  2 d 00 b000000d 1
1 e 0e a000000e 1  1 f 0f b000000f 1
0 0 10 a0000010 1  0 1 11 b0000011 1
0 2 12 ffffffff 1  3 3 13 b0000013 1
2 4 14 a0000014 1  0 5 15 00000000 1
0 6 00 a0000016 0  0 7 17 b0000017 1
3 8 18 a0000018 1  1 9 19 b0000019 1
0 a 1a a000001a 1  2 b 1b b000001b 0
1 c 1c a000001c 1  0 d 1d b000001d 1
0 e 1e a000001e 1  3 f 1f b000001f 1
2 0 01 a0000020 1  0 1 00 b0000021 1
0 2 02 a0000022 1  1 3 03 b0000023 1
0 4 04 12345678 1  0 5 05 b0000025 1
3 6 06 a0000026 1  2 7 07 b0000027 1
0 8 08 a0000028 0  0 9 09 b0000029 1
1 a 00 a000002a 1  3 b 0b b000002b 1
0 c 0c a000002c 1  0 d 0d 87654321 1
2 e 0e a000002e 1  1 f 0f b000002f 0
0 0 10 a0000030 1  2 1 11 b0000031 1
0 2 12 a0000032 1  0 3 00 b0000033 1
3 4 14 a0000034 1  0 5 15 b0000035 1
0 6 16 a0000036 1  3 7 17 b0000037 1
1 8 00 a0000038 0  0 9 19 b0000039 1
0 a 1a a000003a 1  1 b 1b b000003b 1
2 c 1c a000003c 1  0 d 1d b000003d 1
0 e 1e a000003e 1  2 f 00 b000003f 1
1 0 01 a0000040 1  0 1 02 b0000041 0
0 2 03 a0000042 1  3 3 04 b0000043 1
2 4 05 a0000044 1  0 5 06 b0000045 1
0 6 00 a0000046 1  1 7 08 b0000047 1

//--- build.f
+incdir+design
design/wb_pkg.sv
design/wb_seq_arbiter.sv
design/wb_stage.sv
design/wb_rob.sv
design/wb_commit_top.sv
verif/wb_commit_chk.sv
verif/wb_commit_tb.sv

//--- Makefile
# Verilator flow for the writeback/commit testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = wb_commit_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(wildcard design/*.sv design/*.svh verif/*.sv)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Log is searched for the failure line, a missing pass line also fails
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/wb_commit_tb.sv
//----------------------------------------
// Testbench for the writeback/commit unit
// Pattern file holds records for 2 pipes
// Run from the project root
//----------------------------------------

`timescale 1ns/1ps

`include "wb_settings.svh"

module wb_commit_tb import wb_pkg::*; ();

  localparam int NP       = `WB_NUM_PIPES;
  localparam int DEPTH    = `WB_ROB_DEPTH;
  localparam int FIELDS   = 5;                  // offset seq waddr wdata wen
  localparam int MAX_RECS = 256;
  localparam int WORDS    = MAX_RECS * NP * FIELDS;

  logic               clk;
  logic               rst;
  logic      [NP-1:0] x_val;
  x_result_t [NP-1:0] x_result;
  logic      [NP-1:0] x_rdy;
  complete_t          complete;
  commit_t            commit;

  logic [31:0] pat_mem [WORDS];
  x_result_t   acc_q [$];      // Accepted but not yet committed
  int          rec [NP];       // Next record per pipe
  int          idle [NP];
  logic        loaded [NP];
  logic [NP-1:0] xfer;
  integer      seed;
  int          num_recs, limit, cyc, commit_cnt, lat_due;
  int          mismatch_errs, other_errs;
  seq_t        lat_seq;
  logic        all_done;

  always #50 clk = ~clk;

  wb_commit_top uut (
    .clk      (clk),
    .rst      (rst),
    .x_val    (x_val),
    .x_result (x_result),
    .x_rdy    (x_rdy),
    .complete (complete),
    .commit   (commit)
  );

  bind wb_commit_top wb_commit_chk #(.NUM_PIPES(NUM_PIPES)) u_chk (
    .clk      (clk),
    .rst      (rst),
    .x_val    (x_val),
    .x_result (x_result),
    .x_rdy    (x_rdy),
    .commit   (commit)
  );

  function automatic logic [31:0] pat_field(int r, int p, int f);
    return pat_mem[(r * NP + p) * FIELDS + f];
  endfunction

  // Oldest valid request by modulo age from the head
  function automatic logic [NP-1:0] oldest_grant(logic [NP-1:0] val,
                                                 x_result_t [NP-1:0] res, seq_t hd);
    logic [NP-1:0] g;
    int            best;
    int            age;
    g    = '0;
    best = DEPTH;
    for (int p = 0; p < NP; p++) begin
      age = (int'(res[p].seq) - int'(hd) + DEPTH) % DEPTH;
      if (val[p] && age < best) begin
        best = age;
        g    = '0;
        g[p] = 1'b1;
      end
    end
    return g;
  endfunction

  //--------------------------------------
  // Compare tasks
  //--------------------------------------
  task automatic check_rdy(logic [NP-1:0] got, logic [NP-1:0] exp);
    if (got !== exp) begin
      mismatch_errs++;
      $display("Mismatch at %0t: x_rdy got %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_complete(complete_t got, complete_t exp);
    if (got.val !== exp.val || (exp.val && got !== exp)) begin
      mismatch_errs++;
      $display("Mismatch at %0t: complete got %p, expected %p", $time, got, exp);
    end
  endtask

  task automatic check_commit(commit_t got, commit_t exp);
    if (got.val !== exp.val || (exp.val && got !== exp)) begin
      mismatch_errs++;
      $display("Mismatch at %0t: commit got %p, expected %p", $time, got, exp);
    end
  endtask

  //--------------------------------------
  // Falling edge drive of one result per pipe
  //--------------------------------------
  task automatic drive_inputs();
    int n;
    int gap;
    for (int p = 0; p < NP; p++) begin
      if (xfer[p]) begin
        rec[p]++;
        loaded[p] = 1'b0;
        x_val[p]  = 1'b0;
      end
      if (!loaded[p] && rec[p] < num_recs) begin
        gap       = $random(seed);
        idle[p]   = int'(pat_field(rec[p], p, 0)) + (gap & 3);
        loaded[p] = 1'b1;
      end
      n = rec[p] * NP + p;      // Unwrapped sequence index
      if (loaded[p] && !x_val[p]) begin
        if (idle[p] > 0) begin
          idle[p]--;
        end else if (n < commit_cnt + DEPTH) begin   // Keep at most DEPTH in flight
          x_result[p].pc    = 32'h0000_1000 + 32'(n * 4);
          x_result[p].seq   = seq_t'(pat_field(rec[p], p, 1));
          x_result[p].waddr = 5'(pat_field(rec[p], p, 2));
          x_result[p].wdata = pat_field(rec[p], p, 3);
          x_result[p].wen   = 1'(pat_field(rec[p], p, 4));
          x_val[p]          = 1'b1;
        end
      end
    end
  endtask

  //--------------------------------------
  // Mid-cycle sampling and reference model
  //--------------------------------------
  task automatic sample_outputs();
    seq_t          hd;
    logic [NP-1:0] exp_rdy;
    complete_t     exp_cpl;
    commit_t       exp_cmt;
    int            idx;
    hd      = seq_t'(commit_cnt % DEPTH);
    exp_rdy = (cyc <= 3) ? '0 : oldest_grant(x_val, x_result, hd);
    check_rdy(x_rdy, exp_rdy);
    xfer    = x_val & x_rdy;
    exp_cpl = '0;
    for (int p = 0; p < NP; p++) begin
      if (x_val[p] && exp_rdy[p]) begin
        exp_cpl.val   = 1'b1;
        exp_cpl.seq   = x_result[p].seq;
        exp_cpl.waddr = x_result[p].waddr;
        exp_cpl.wdata = x_result[p].wdata;
        exp_cpl.wen   = x_result[p].wen && (x_result[p].waddr != 5'd0);
      end
      if (xfer[p]) begin
        acc_q.push_back(x_result[p]);
        if (x_result[p].seq == hd) begin
          lat_due = cyc + 2;
          lat_seq = x_result[p].seq;
        end
      end
    end
    check_complete(complete, exp_cpl);
    if (cyc == lat_due && !(commit.val === 1'b1 && commit.seq == lat_seq)) begin
      mismatch_errs++;
      $display("Mismatch at %0t: seq %0d not committed two edges after transfer",
               $time, lat_seq);
    end
    exp_cmt = '0;
    if (cyc <= 3) begin
      check_commit(commit, exp_cmt);
    end else if (commit.val === 1'b1) begin
      idx = -1;
      for (int i = 0; i < acc_q.size(); i++) begin
        if (acc_q[i].seq == hd) idx = i;
      end
      if (idx < 0) begin
        other_errs++;
        $display("Error at %0t: commit while seq %0d was never accepted", $time, hd);
      end else begin
        exp_cmt.val   = 1'b1;
        exp_cmt.seq   = hd;
        exp_cmt.pc    = acc_q[idx].pc;
        exp_cmt.waddr = acc_q[idx].waddr;
        exp_cmt.wdata = acc_q[idx].wdata;
        exp_cmt.wen   = acc_q[idx].wen && (acc_q[idx].waddr != 5'd0);
        check_commit(commit, exp_cmt);
        acc_q.delete(idx);
      end
      commit_cnt++;
    end
    all_done = (num_recs > 0) && (commit_cnt >= num_recs * NP);
  endtask

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    x_val    = '0;
    x_result = '0;
    seed     = 32'hcdd1;
    xfer     = '0;
    cyc      = 0;
    lat_due  = -1;
    all_done = 1'b0;
    commit_cnt    = 0;
    mismatch_errs = 0;
    other_errs    = 0;
    for (int i = 0; i < WORDS; i++) pat_mem[i] = ~32'(i);
    $readmemh("verif/wb_patterns.txt", pat_mem);
    num_recs = 0;
    while (num_recs < MAX_RECS &&
           pat_field(num_recs, 0, 0) !== ~32'(num_recs * NP * FIELDS)) begin
      num_recs++;
    end
    if (num_recs == 0) begin
      other_errs++;
      $display("Error: pattern file holds no records");
    end
    for (int p = 0; p < NP; p++) begin
      rec[p]    = 0;
      idle[p]   = 0;
      loaded[p] = 1'b0;
    end
    limit = 20 * num_recs + 200;

    while (num_recs > 0 && !all_done && cyc < limit) begin
      @(negedge clk);
      if (cyc == 3) rst = 1'b0;     // Four rising edges in reset
      drive_inputs();
      #10;
      sample_outputs();
      cyc++;
    end

    if (num_recs > 0 && !all_done) begin
      other_errs++;
      $display("Timeout: %0d of %0d results committed after %0d cycles",
               commit_cnt, num_recs * NP, cyc);
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
    if (mismatch_errs + other_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- verif/wb_commit_chk.sv
//----------------------------------------
// Handshake and commit order assertions
// Bound into wb_commit_top
//----------------------------------------

`timescale 1ns/1ps

`include "wb_settings.svh"

module wb_commit_chk import wb_pkg::*; #(
  parameter int NUM_PIPES = `WB_NUM_PIPES
) (
  input logic                      clk,
  input logic                      rst,
  input logic      [NUM_PIPES-1:0] x_val,
  input x_result_t [NUM_PIPES-1:0] x_result,
  input logic      [NUM_PIPES-1:0] x_rdy,
  input commit_t                   commit
);

  seq_t                     next_seq;   // Seq the next commit must carry
  logic [`WB_ROB_DEPTH-1:0] pending;    // Transferred and not yet committed

  always_ff @(posedge clk) begin
    if (rst) begin
      next_seq <= '0;
      pending  <= '0;
    end else begin
      if (commit.val) begin
        next_seq            <= next_seq + 1'b1;
        pending[commit.seq] <= 1'b0;
      end
      for (int i = 0; i < NUM_PIPES; i++) begin
        if (x_val[i] && x_rdy[i]) begin
          pending[x_result[i].seq] <= 1'b1;
        end
      end
    end
  end

  rdy_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(x_rdy))
    else $error("x_rdy grants more than one pipe");

  rdy_needs_val: assert property (@(posedge clk) disable iff (rst) (x_rdy & ~x_val) == '0)
    else $error("x_rdy high on a pipe without x_val");

  // Checked from the second reset edge on
  no_commit_in_rst: assert property (@(posedge clk) rst && $past(rst) |-> !commit.val)
    else $error("commit.val high during reset");

  commit_in_order: assert property (@(posedge clk) disable iff (rst)
                                    commit.val |->
                                    (commit.seq == next_seq) && pending[commit.seq])
    else $error("commit seq out of order or never transferred");

endmodule

//--- design/wb_commit_top.sv
//----------------------------------------
// Writeback and commit unit
// Valid/ready on execute inputs only
// complete and commit are valid-only
//----------------------------------------

`timescale 1ns/1ps

`include "wb_settings.svh"

module wb_commit_top import wb_pkg::*; #(
  parameter int NUM_PIPES = `WB_NUM_PIPES
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic      [NUM_PIPES-1:0] x_val,
  input  x_result_t [NUM_PIPES-1:0] x_result,
  output logic      [NUM_PIPES-1:0] x_rdy,
  output complete_t                 complete,
  output commit_t                   commit
);

  logic [NUM_PIPES-1:0] grant;
  seq_t [NUM_PIPES-1:0] x_seq;
  seq_t                 head;
  logic                 stage_val;
  seq_t                 stage_seq;
  rob_entry_t           stage_entry;

  for (genvar i = 0; i < NUM_PIPES; i++) begin : g_seq
    assign x_seq[i] = x_result[i].seq;
  end

  assign x_rdy = grant;   // Winner transfers this cycle

  wb_seq_arbiter #(.NUM_PIPES(NUM_PIPES)) u_arb (
    .clk   (clk),
    .rst   (rst),
    .x_val (x_val),
    .x_seq (x_seq),
    .head  (head),
    .grant (grant)
  );

  wb_stage #(.NUM_PIPES(NUM_PIPES)) u_stage (
    .clk         (clk),
    .rst         (rst),
    .x_result    (x_result),
    .grant       (grant),
    .complete    (complete),
    .stage_val   (stage_val),
    .stage_seq   (stage_seq),
    .stage_entry (stage_entry)
  );

  wb_rob u_rob (
    .clk       (clk),
    .rst       (rst),
    .ins_val   (stage_val),
    .ins_seq   (stage_seq),
    .ins_entry (stage_entry),
    .head      (head),
    .commit    (commit)
  );

endmodule

//--- design/wb_rob.sv
//----------------------------------------
// Reorder buffer, one slot per seq number
// At most WB_ROB_DEPTH results in flight
// Commit has no back-pressure
//----------------------------------------

`timescale 1ns/1ps

`include "wb_settings.svh"

module wb_rob import wb_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       ins_val,
  input  seq_t       ins_seq,
  input  rob_entry_t ins_entry,
  output seq_t       head,
  output commit_t    commit
);

  localparam int DEPTH = `WB_ROB_DEPTH;

  rob_entry_t  mem   [DEPTH];   // Payload storage
  slot_state_e state [DEPTH];
  seq_t        head_q;
  rob_entry_t  head_entry;
  logic        head_full;

  assign head       = head_q;
  assign head_entry = mem[head_q];
  assign head_full  = (state[head_q] == SLOT_FULL);

  //--------------------------------------
  // Commit notice from the head slot
  //--------------------------------------
  always_comb begin
    commit.val   = head_full;
    commit.seq   = head_q;
    commit.pc    = head_entry.pc;
    commit.waddr = head_entry.waddr;
    commit.wdata = head_entry.wdata;
    commit.wen   = head_entry.wen;
  end

  //--------------------------------------
  // Slot state and head pointer
  //--------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      head_q <= '0;
      for (int i = 0; i < DEPTH; i++) begin
        state[i] <= SLOT_EMPTY;
      end
    end else begin
      if (head_full) begin
        state[head_q] <= SLOT_EMPTY;
        head_q        <= head_q + 1'b1;   // Wraps past DEPTH-1
      end
      // Insert never targets a full head since seqs are unique
      if (ins_val) begin
        state[ins_seq] <= SLOT_FULL;
      end
    end
  end

  // Payload write, indexed by seq
  always_ff @(posedge clk) begin
    if (ins_val) begin
      mem[ins_seq] <= ins_entry;
    end
  end

endmodule

//--- design/wb_stage.sv
//----------------------------------------
// Writeback register stage
// Grant must be one-hot or zero
// Completion is combinational off grant
//----------------------------------------

`timescale 1ns/1ps

`include "wb_settings.svh"

module wb_stage import wb_pkg::*; #(
  parameter int NUM_PIPES = `WB_NUM_PIPES
) (
  input  logic                      clk,
  input  logic                      rst,
  input  x_result_t [NUM_PIPES-1:0] x_result,
  input  logic      [NUM_PIPES-1:0] grant,
  output complete_t                 complete,
  output logic                      stage_val,
  output seq_t                      stage_seq,
  output rob_entry_t                stage_entry
);

  localparam int RES_W = $bits(x_result_t);

  x_result_t sel;        // Granted result
  logic      sel_val;
  logic      sel_wen;    // wen with register 0 filtered

  //--------------------------------------
  // Select granted pipe
  //--------------------------------------
  always_comb begin
    sel     = '0;
    sel_val = 1'b0;
    for (int i = 0; i < NUM_PIPES; i++) begin
      // Mask with the grant bit, then OR everything together
      sel     = sel | (x_result[i] & {RES_W{grant[i]}});
      sel_val = sel_val | grant[i];
    end
  end

  // Register 0 is hardwired, never written
  assign sel_wen = sel.wen && (sel.waddr != '0);

  //--------------------------------------
  // Completion notice
  //--------------------------------------
  always_comb begin
    complete.val   = sel_val;
    complete.seq   = sel.seq;
    complete.waddr = sel.waddr;
    complete.wdata = sel.wdata;
    complete.wen   = sel_wen;
  end

  //--------------------------------------
  // Pipeline register toward the ROB
  //--------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      stage_val <= 1'b0;
    end else begin
      stage_val <= sel_val;
    end
  end

  // Payload only moves on a transfer
  always_ff @(posedge clk) begin
    if (sel_val) begin
      stage_seq         <= sel.seq;
      stage_entry.pc    <= sel.pc;
      stage_entry.waddr <= sel.waddr;
      stage_entry.wdata <= sel.wdata;
      stage_entry.wen   <= sel_wen;
    end
  end

endmodule

//--- design/wb_seq_arbiter.sv
//----------------------------------------
// Oldest-first arbiter over execute pipes
// Age is seq minus head, modulo the depth
// Assumes unique seq numbers in flight
//----------------------------------------

`timescale 1ns/1ps

`include "wb_settings.svh"

module wb_seq_arbiter import wb_pkg::*; #(
  parameter int NUM_PIPES = `WB_NUM_PIPES
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [NUM_PIPES-1:0] x_val,
  input  seq_t [NUM_PIPES-1:0] x_seq,
  input  seq_t                 head,
  output logic [NUM_PIPES-1:0] grant
);

  // Tree padded up to a power of two in heap layout with root at 0
  localparam int LEVELS = $clog2(NUM_PIPES);
  localparam int PAD    = 1 << LEVELS;
  localparam int IDX_W  = (LEVELS > 0) ? LEVELS : 1;
  localparam int NODES  = 2 * PAD - 1;

  logic             node_val [NODES];
  seq_t             node_age [NODES];
  logic [IDX_W-1:0] node_idx [NODES];

  // No grants until the first edge after reset release
  logic arb_en;

  always_ff @(posedge clk) begin
    if (rst) begin
      arb_en <= 1'b0;
    end else begin
      arb_en <= 1'b1;
    end
  end

  //--------------------------------------
  // Leaves
  //--------------------------------------
  for (genvar j = 0; j < PAD; j++) begin : g_leaf
    if (j < NUM_PIPES) begin : g_real
      assign node_val[PAD-1+j] = x_val[j];
      assign node_age[PAD-1+j] = x_seq[j] - head;   // Wraps modulo depth
      assign node_idx[PAD-1+j] = IDX_W'(j);
    end else begin : g_pad
      assign node_val[PAD-1+j] = 1'b0;
      assign node_age[PAD-1+j] = '1;
      assign node_idx[PAD-1+j] = '0;
    end
  end

  //--------------------------------------
  // Comparison tree
  //--------------------------------------
  for (genvar k = 0; k < PAD - 1; k++) begin : g_node
    logic pick_r;

    // Right child wins only if valid and strictly older
    assign pick_r = node_val[2*k+2] &&
                    (!node_val[2*k+1] || (node_age[2*k+2] < node_age[2*k+1]));

    assign node_val[k] = node_val[2*k+1] | node_val[2*k+2];
    assign node_age[k] = pick_r ? node_age[2*k+2] : node_age[2*k+1];
    assign node_idx[k] = pick_r ? node_idx[2*k+2] : node_idx[2*k+1];
  end

  // One-hot decode of the winner
  for (genvar j = 0; j < NUM_PIPES; j++) begin : g_grant
    assign grant[j] = arb_en && node_val[0] && (node_idx[0] == IDX_W'(j));
  end

endmodule

//--- design/wb_pkg.sv
//----------------------------------------
// Shared writeback and commit types
// Field widths assume 32-bit pc/data
// and 32 architectural registers
//----------------------------------------

`include "wb_settings.svh"

package wb_pkg;

  typedef logic [`WB_SEQ_BITS-1:0] seq_t;

  // Result handed over by one execute pipe (74 bits)
  typedef struct packed {
    logic [31:0] pc;
    seq_t        seq;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    logic        wen;
  } x_result_t;

  // Wakeup and bypass notice, same cycle as the transfer
  typedef struct packed {
    logic        val;
    seq_t        seq;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    logic        wen;     // Already low for register 0
  } complete_t;

  // In-order release notice
  typedef struct packed {
    logic        val;
    seq_t        seq;
    logic [31:0] pc;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    logic        wen;
  } commit_t;

  // Payload kept per ROB slot (70 bits), seq is the slot index
  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  waddr;
    logic [31:0] wdata;
    logic        wen;
  } rob_entry_t;

  typedef enum logic {
    SLOT_EMPTY = 1'b0,
    SLOT_FULL  = 1'b1
  } slot_state_e;

endpackage

//--- design/wb_settings.svh
//----------------------------------------
// Writeback and commit configuration
// Pipe count is supported from 1 to 4
// ROB depth must stay 2**WB_SEQ_BITS
//----------------------------------------

`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// Number of execute pipes feeding writeback
`define WB_NUM_PIPES 2

// Sequence number width, wraps modulo the ROB depth
`define WB_SEQ_BITS 4

// One ROB slot per sequence number
`define WB_ROB_DEPTH (1 << `WB_SEQ_BITS)

`endif
